// File: verilog/riscv_defines.sv
package riscv_defines;

    // ******************************
    // datapath widths
    // ******************************

    localparam int XLEN    = 32;    // data and address width
    localparam int CAUSE_W = 4;     // trap cause field

    // ******************************
    // trap causes
    // ******************************

    // fetch side only, other causes are raised further down the pipe
    localparam logic [CAUSE_W-1:0] CAUSE_INST_MISALIGNED   = 4'd0;
    localparam logic [CAUSE_W-1:0] CAUSE_INST_ACCESS_FAULT = 4'd1;

    // ******************************
    // encodings and reset values
    // ******************************

    localparam logic [XLEN-1:0] INST_NOP = 32'h0000_0013;  // addi x0, x0, 0

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;  // first fetch address

endpackage

// File: verilog/pcnext_selector.sv
`timescale 1ns/1ps

module pcnext_selector (
    input  logic [riscv_defines::XLEN-1:0] pcplus4_f,
    input  logic [riscv_defines::XLEN-1:0] pc_jump,
    input  logic [riscv_defines::XLEN-1:0] pc_return,
    input  logic [riscv_defines::XLEN-1:0] pc_pred,
    input  logic [riscv_defines::XLEN-1:0] trap_addr,

    input  logic                           trap_redir,
    input  logic                           mispredict,
    input  logic                           cflow_taken,
    input  logic                           pred_taken,

    output logic [riscv_defines::XLEN-1:0] pc_next
);

    // ******************************
    // redirect priority
    // ******************************

    // a resolved mispredict always overrides a fresh prediction,
    // and a trap overrides everything in flight
    always_comb begin
        if (trap_redir) begin
            pc_next = trap_addr;            // trap handler entry
        end else if (mispredict && cflow_taken) begin
            pc_next = pc_jump;              // taken, predictor said no
        end else if (mispredict) begin
            pc_next = pc_return;            // not taken after all
        end else if (pred_taken) begin
            pc_next = pc_pred;
        end else begin
            pc_next = pcplus4_f;            // plain sequential fetch
        end
    end

endmodule

// File: verilog/program_counter.sv
`timescale 1ns/1ps

module program_counter (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           start,
    input  logic                           stall_f,
    input  logic [riscv_defines::XLEN-1:0] pc_next,

    output logic [riscv_defines::XLEN-1:0] pc
);

    import riscv_defines::*;

    // pinned at the reset vector until the core is told to run
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (!start) begin
            pc <= RESET_PC;
        end else if (!stall_f) begin
            pc <= pc_next;
        end
        // stalled, keep current fetch address
    end

endmodule

// File: verilog/instruction_memory.sv
`timescale 1ns/1ps

module instruction_memory #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                           clk,
    input  logic                           arst_n,

    // fetch side
    input  logic [riscv_defines::XLEN-1:0] pc,
    input  logic                           instmisalign,
    input  logic                           flush_d,
    input  logic                           stall_d,

    // program load port
    input  logic                           imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0]  imem_waddr,
    input  logic [riscv_defines::XLEN-1:0] imem_wdata,

    output logic                           imemfault,
    output logic [riscv_defines::XLEN-1:0] inst
);

    import riscv_defines::*;

    localparam int IDX_W = $clog2(IMEM_WORDS);
    localparam int WA_W  = XLEN - 2;            // byte address to word address

    logic [XLEN-1:0]  mem [IMEM_WORDS];

    logic [WA_W-1:0]  word_addr;
    logic [IDX_W-1:0] rd_idx;
    logic             fetch_bad;

    // ******************************
    // address decode
    // ******************************

    assign word_addr = pc[XLEN-1:2];
    assign rd_idx    = word_addr[IDX_W-1:0];

    // anything past the last word is an access fault
    assign imemfault = (word_addr >= WA_W'(IMEM_WORDS));

    assign fetch_bad = instmisalign || imemfault;

    // ******************************
    // storage
    // ******************************

    // write lands on the edge; a fetch of the same word that
    // cycle still sees the previous contents
    always_ff @(posedge clk) begin
        if (imem_we) begin
            mem[imem_waddr] <= imem_wdata;
        end
    end

    // ******************************
    // fetch/decode register
    // ******************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst <= INST_NOP;
        end else if (flush_d) begin
            inst <= INST_NOP;               // flush beats stall
        end else if (!stall_d) begin
            if (fetch_bad) begin
                inst <= INST_NOP;           // trap is reported from stage_if
            end else begin
                inst <= mem[rd_idx];
            end
        end
    end

endmodule

// File: verilog/stage_if.sv
`timescale 1ns/1ps

module stage_if #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              start,

    // predictor and resolved control flow
    input  logic [riscv_defines::XLEN-1:0]    pc_pred,
    input  logic [riscv_defines::XLEN-1:0]    pc_jump,
    input  logic [riscv_defines::XLEN-1:0]    pc_return,
    input  logic                              mispredict,
    input  logic                              cflow_taken,
    input  logic                              pred_taken,

    // trap controller redirect
    input  logic                              trap_redir,
    input  logic [riscv_defines::XLEN-1:0]    trap_addr,

    // hazard unit
    input  logic                              stall_f,
    input  logic                              stall_d,
    input  logic                              flush_d,

    // program load
    input  logic                              imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0]     imem_waddr,
    input  logic [riscv_defines::XLEN-1:0]    imem_wdata,

    output logic [riscv_defines::XLEN-1:0]    pc_f,
    output logic [riscv_defines::XLEN-1:0]    pcplus4_f,
    output logic [riscv_defines::XLEN-1:0]    inst_f,

    // fetch trap request
    output logic                              trap_valid,
    output logic [riscv_defines::CAUSE_W-1:0] trap_cause,
    output logic [riscv_defines::XLEN-1:0]    trap_pc
);

    import riscv_defines::*;

    logic [XLEN-1:0] pc_next;
    logic            instmisalign;
    logic            imemfault;

    // ******************************
    // program counter
    // ******************************

    assign pcplus4_f = pc_f + XLEN'(4);

    pcnext_selector pcnext_selector (
        .pcplus4_f    (pcplus4_f),
        .pc_jump      (pc_jump),
        .pc_return    (pc_return),
        .pc_pred      (pc_pred),
        .trap_addr    (trap_addr),
        .trap_redir   (trap_redir),
        .mispredict   (mispredict),
        .cflow_taken  (cflow_taken),
        .pred_taken   (pred_taken),
        .pc_next      (pc_next)
    );

    program_counter program_counter (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),        // holds pc at zero until set
        .stall_f      (stall_f),
        .pc_next      (pc_next),
        .pc           (pc_f)
    );

    // no compressed instructions, so word alignment is required
    assign instmisalign = |pc_f[1:0];

    // ******************************
    // instruction memory
    // ******************************

    instruction_memory #(
        .IMEM_WORDS   (IMEM_WORDS)
    ) instruction_memory (
        .clk          (clk),
        .arst_n       (arst_n),
        .pc           (pc_f),
        .instmisalign (instmisalign),
        .flush_d      (flush_d),
        .stall_d      (stall_d),
        .imem_we      (imem_we),
        .imem_waddr   (imem_waddr),
        .imem_wdata   (imem_wdata),
        .imemfault    (imemfault),
        .inst         (inst_f)
    );

    // ******************************
    // trap request
    // ******************************

    // misalignment is reported ahead of an access fault
    always_comb begin
        trap_valid = 1'b0;
        trap_cause = '0;
        trap_pc    = '0;
        if (start) begin
            if (instmisalign) begin
                trap_valid = 1'b1;
                trap_cause = CAUSE_INST_MISALIGNED;
                trap_pc    = pc_f;          // also serves as tval
            end else if (imemfault) begin
                trap_valid = 1'b1;
                trap_cause = CAUSE_INST_ACCESS_FAULT;
                trap_pc    = pc_f;
            end
        end
    end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// File: test/stage_if_sva.sv
`timescale 1ns/1ps

module stage_if_sva (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              start,
    input  logic                              stall_d,
    input  logic                              flush_d,
    input  logic [riscv_defines::XLEN-1:0]    pc_f,
    input  logic [riscv_defines::XLEN-1:0]    pcplus4_f,
    input  logic [riscv_defines::XLEN-1:0]    inst_f,
    input  logic                              trap_valid,
    input  logic [riscv_defines::XLEN-1:0]    trap_pc
);

    import riscv_defines::*;

    // ******************************
    // fetch output rules
    // ******************************

    a_pcplus4: assert property (@(posedge clk) disable iff (!arst_n)
        pcplus4_f == pc_f + XLEN'(4))
        else $error("pcplus4_f differs from pc_f plus four");

    a_no_trap_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !start |-> !trap_valid)
        else $error("trap_valid raised while start is low");

    a_trap_pc: assert property (@(posedge clk) disable iff (!arst_n)
        trap_valid |-> trap_pc == pc_f)
        else $error("trap_pc differs from pc_f on a trap");

    // held decode word, flush excluded
    a_stall_d: assert property (@(posedge clk) disable iff (!arst_n)
        (stall_d && !flush_d) |=> $stable(inst_f))
        else $error("inst_f changed after a decode stall");

endmodule

bind stage_if stage_if_sva sva (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .stall_d    (stall_d),
    .flush_d    (flush_d),
    .pc_f       (pc_f),
    .pcplus4_f  (pcplus4_f),
    .inst_f     (inst_f),
    .trap_valid (trap_valid),
    .trap_pc    (trap_pc)
);

// File: test/stage_if_tb.sv
`timescale 1ns/1ps

module stage_if_tb;

    import riscv_defines::*;

    localparam int IMEM_WORDS      = 64;
    localparam int AW              = $clog2(IMEM_WORDS);
    localparam int CLK_PERIOD      = 10;
    localparam int N_ROWS          = 29;
    localparam int WATCHDOG_CYCLES = N_ROWS * 20;

    localparam logic [XLEN-1:0] MEM_BYTES  = XLEN'(IMEM_WORDS * 4);
    localparam logic [XLEN-1:0] OFS_RETURN = 32'h10;    // offsets from the row target
    localparam logic [XLEN-1:0] OFS_JUMP   = 32'h20;
    localparam logic [XLEN-1:0] OFS_TRAP   = 32'h30;

    logic              clk;
    logic              arst_n;
    logic              start;
    logic [XLEN-1:0]   pc_pred;
    logic [XLEN-1:0]   pc_jump;
    logic [XLEN-1:0]   pc_return;
    logic              mispredict;
    logic              cflow_taken;
    logic              pred_taken;
    logic              trap_redir;
    logic [XLEN-1:0]   trap_addr;
    logic              stall_f;
    logic              stall_d;
    logic              flush_d;
    logic              imem_we;
    logic [AW-1:0]     imem_waddr;
    logic [XLEN-1:0]   imem_wdata;
    logic [XLEN-1:0]   pc_f;
    logic [XLEN-1:0]   pcplus4_f;
    logic [XLEN-1:0]   inst_f;
    logic              trap_valid;
    logic [CAUSE_W-1:0] trap_cause;
    logic [XLEN-1:0]   trap_pc;

    // redir bits are {trap, mispredict, cflow, pred}
    // stalls bits are {f, d, flush}
    string             row_name   [N_ROWS];
    logic              row_start  [N_ROWS];
    logic [3:0]        row_redir  [N_ROWS];
    logic [2:0]        row_stalls [N_ROWS];
    logic [XLEN-1:0]   row_tgt    [N_ROWS];
    logic [XLEN-1:0]   row_pc     [N_ROWS];
    int                n_rows;

    logic [XLEN-1:0]   model_mem [IMEM_WORDS];
    logic [XLEN-1:0]   m_pc;
    logic [XLEN-1:0]   m_inst;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(16)) clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    stage_if #(.IMEM_WORDS(IMEM_WORDS)) DUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .pc_pred     (pc_pred),
        .pc_jump     (pc_jump),
        .pc_return   (pc_return),
        .mispredict  (mispredict),
        .cflow_taken (cflow_taken),
        .pred_taken  (pred_taken),
        .trap_redir  (trap_redir),
        .trap_addr   (trap_addr),
        .stall_f     (stall_f),
        .stall_d     (stall_d),
        .flush_d     (flush_d),
        .imem_we     (imem_we),
        .imem_waddr  (imem_waddr),
        .imem_wdata  (imem_wdata),
        .pc_f        (pc_f),
        .pcplus4_f   (pcplus4_f),
        .inst_f      (inst_f),
        .trap_valid  (trap_valid),
        .trap_cause  (trap_cause),
        .trap_pc     (trap_pc)
    );

    // ******************************
    // helpers
    // ******************************

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [XLEN-1:0] model_next_pc(input logic [XLEN-1:0] pc,
            input logic start_in, input logic [3:0] redir, input logic hold,
            input logic [XLEN-1:0] tgt);
        if (!start_in)
            return RESET_PC;
        if (hold)
            return pc;
        if (redir[3])
            return tgt + OFS_TRAP;
        if (redir[2] && redir[1])
            return tgt + OFS_JUMP;
        if (redir[2])
            return tgt + OFS_RETURN;
        if (redir[0])
            return tgt;
        return pc + 32'd4;
    endfunction

    function automatic logic [XLEN-1:0] model_next_inst(input logic [XLEN-1:0] pc,
            input logic [XLEN-1:0] cur, input logic hold, input logic flush);
        if (flush)
            return INST_NOP;
        if (hold)
            return cur;
        if (pc[1:0] != 2'b00 || pc >= MEM_BYTES)
            return INST_NOP;
        return model_mem[pc[AW+1:2]];
    endfunction

    task automatic check_value(input string name, input string what,
            input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: row %s %s expected %h actual %h", name, what, expected, actual);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_row(input string name, input logic start_in, input logic [3:0] redir,
            input logic [2:0] stalls, input logic [XLEN-1:0] tgt, input logic [XLEN-1:0] exp_pc);
        row_name[n_rows]   = name;
        row_start[n_rows]  = start_in;
        row_redir[n_rows]  = redir;
        row_stalls[n_rows] = stalls;
        row_tgt[n_rows]    = tgt;
        row_pc[n_rows]     = exp_pc;
        n_rows++;
    endtask

    task automatic drive_row(input int i);
        start       <= row_start[i];
        trap_redir  <= row_redir[i][3];
        mispredict  <= row_redir[i][2];
        cflow_taken <= row_redir[i][1];
        pred_taken  <= row_redir[i][0];
        pc_pred     <= row_tgt[i];
        pc_return   <= row_tgt[i] + OFS_RETURN;
        pc_jump     <= row_tgt[i] + OFS_JUMP;
        trap_addr   <= row_tgt[i] + OFS_TRAP;
        stall_f     <= row_stalls[i][2];
        stall_d     <= row_stalls[i][1];
        flush_d     <= row_stalls[i][0];
        imem_we     <= 1'b0;
    endtask

    task automatic check_row(input int i);
        logic              exp_valid;
        logic [CAUSE_W-1:0] exp_cause;
        logic [XLEN-1:0]   exp_tpc;
        exp_valid = 1'b0;
        exp_cause = '0;
        exp_tpc   = '0;
        if (row_start[i] && m_pc[1:0] != 2'b00) begin
            exp_valid = 1'b1;
            exp_cause = CAUSE_INST_MISALIGNED;      // wins over the range fault
            exp_tpc   = m_pc;
        end else if (row_start[i] && m_pc >= MEM_BYTES) begin
            exp_valid = 1'b1;
            exp_cause = CAUSE_INST_ACCESS_FAULT;
            exp_tpc   = m_pc;
        end
        check_value(row_name[i], "pc_f (table)", row_pc[i], pc_f);
        check_value(row_name[i], "pc_f (model)", m_pc, pc_f);
        check_value(row_name[i], "pcplus4_f", m_pc + 32'd4, pcplus4_f);
        check_value(row_name[i], "inst_f", m_inst, inst_f);
        check_value(row_name[i], "trap_valid", 32'(exp_valid), 32'(trap_valid));
        check_value(row_name[i], "trap_cause", 32'(exp_cause), 32'(trap_cause));
        check_value(row_name[i], "trap_pc", exp_tpc, trap_pc);
    endtask

    // ******************************
    // stimulus table
    // ******************************

    task automatic build_table();
        n_rows = 0;
        add_row("idle_a",      1'b0, 4'b0000, 3'b000, 32'h0,   32'h0);
        add_row("idle_pred",   1'b0, 4'b0001, 3'b000, 32'h40,  32'h0);
        add_row("idle_b",      1'b0, 4'b0000, 3'b000, 32'h0,   32'h0);
        add_row("seq_0",       1'b1, 4'b0000, 3'b000, 32'h0,   32'h0);
        add_row("seq_4",       1'b1, 4'b0000, 3'b000, 32'h0,   32'h4);
        add_row("seq_8",       1'b1, 4'b0000, 3'b000, 32'h0,   32'h8);
        add_row("pred_go",     1'b1, 4'b0001, 3'b000, 32'h40,  32'hc);
        add_row("pred_hit",    1'b1, 4'b0000, 3'b000, 32'h0,   32'h40);
        add_row("prio_all",    1'b1, 4'b1111, 3'b000, 32'h80,  32'h44);
        add_row("prio_jump",   1'b1, 4'b0111, 3'b000, 32'h80,  32'hb0);
        add_row("prio_return", 1'b1, 4'b0101, 3'b000, 32'h80,  32'ha0);
        add_row("prio_pred",   1'b1, 4'b0011, 3'b000, 32'h80,  32'h90);
        add_row("cflow_only",  1'b1, 4'b0010, 3'b000, 32'h80,  32'h80);
        add_row("stall_f",     1'b1, 4'b0000, 3'b100, 32'h0,   32'h84);
        add_row("stall_fd",    1'b1, 4'b0000, 3'b110, 32'h0,   32'h84);
        add_row("stall_d",     1'b1, 4'b0000, 3'b010, 32'h0,   32'h84);
        add_row("stall_d_run", 1'b1, 4'b0000, 3'b010, 32'h0,   32'h88);
        add_row("flush_stall", 1'b1, 4'b0000, 3'b011, 32'h0,   32'h8c);
        add_row("pred_odd",    1'b1, 4'b0001, 3'b000, 32'h22,  32'h90);
        add_row("misalign",    1'b1, 4'b0000, 3'b100, 32'h0,   32'h22);
        add_row("misalign_st", 1'b1, 4'b0001, 3'b000, 32'h100, 32'h22);
        add_row("range_fault", 1'b1, 4'b0001, 3'b000, 32'h102, 32'h100);
        add_row("both_faults", 1'b1, 4'b1000, 3'b000, 32'h1,   32'h102);
        add_row("odd_idle",    1'b0, 4'b0000, 3'b000, 32'h0,   32'h31);
        add_row("idle_c",      1'b0, 4'b0000, 3'b000, 32'h0,   32'h0);
        add_row("restart_0",   1'b1, 4'b0000, 3'b000, 32'h0,   32'h0);
        add_row("restart_4",   1'b1, 4'b0000, 3'b000, 32'h0,   32'h4);
        add_row("flush_only",  1'b1, 4'b0000, 3'b001, 32'h0,   32'h8);
        add_row("end_seq",     1'b1, 4'b0000, 3'b000, 32'h0,   32'hc);
    endtask

    // ******************************
    // main sequence
    // ******************************

    initial begin : main
        logic [31:0] lcg_state;
        logic        p_start;
        logic [3:0]  p_redir;
        logic [2:0]  p_stalls;
        logic [XLEN-1:0] p_tgt;

        start       = 1'b0;
        pc_pred     = '0;
        pc_jump     = '0;
        pc_return   = '0;
        mispredict  = 1'b0;
        cflow_taken = 1'b0;
        pred_taken  = 1'b0;
        trap_redir  = 1'b0;
        trap_addr   = '0;
        stall_f     = 1'b0;
        stall_d     = 1'b0;
        flush_d     = 1'b1;     // keeps inst_f at NOP while loading
        imem_we     = 1'b0;
        imem_waddr  = '0;
        imem_wdata  = '0;

        build_table();
        if (n_rows != N_ROWS) begin
            $display("stimulus table holds %0d rows but %0d were expected", n_rows, N_ROWS);
            $display("Test FAILED");
            $fatal(1, "bad table");
        end

        wait (arst_n === 1'b1);

        lcg_state = 32'h53a1060f;
        for (int w = 0; w < IMEM_WORDS; w++) begin
            @(posedge clk);
            lcg_state    = lcg_next(lcg_state);
            model_mem[w] = lcg_state;
            imem_we      <= 1'b1;
            imem_waddr   <= AW'(w);
            imem_wdata   <= lcg_state;
        end

        // state left by the load phase
        m_pc     = RESET_PC;
        m_inst   = INST_NOP;
        p_start  = 1'b0;
        p_redir  = 4'b0000;
        p_stalls = 3'b001;
        p_tgt    = '0;

        for (int i = 0; i < N_ROWS; i++) begin
            @(posedge clk);
            m_inst = model_next_inst(m_pc, m_inst, p_stalls[1], p_stalls[0]);
            m_pc   = model_next_pc(m_pc, p_start, p_redir, p_stalls[2], p_tgt);
            drive_row(i);
            p_start  = row_start[i];
            p_redir  = row_redir[i];
            p_stalls = row_stalls[i];
            p_tgt    = row_tgt[i];
            @(negedge clk);     // outputs settled mid cycle
            check_row(i);
        end

        $display("Test OK");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d clock cycles, the table never finished",
                 WATCHDOG_CYCLES);
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

endmodule

// File: sim.f
verilog/riscv_defines.sv
verilog/pcnext_selector.sv
verilog/program_counter.sv
verilog/instruction_memory.sv
verilog/stage_if.sv
test/tb_clock_gen.sv
test/stage_if_sva.sv
test/stage_if_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch stage testbench with Verilator.
# A failing check ends in $fatal, so the simulator exit status carries the result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sim.f \
    --top-module stage_if_tb \
    -o stage_if_sim

./obj_dir/stage_if_sim
